// File: include/joybus_defs.svh
`ifndef JOYBUS_DEFS_SVH
`define JOYBUS_DEFS_SVH

// line timing, all in sample_clk cycles
`define JOYBUS_LEVEL_WIDTH 2
`define JOYBUS_BIT_WIDTH (4 * `JOYBUS_LEVEL_WIDTH)   // four levels per bit
`define JOYBUS_IDLE_CYCLES 16                        // high time that closes a frame

// frame and reply limits in bytes
`define JOYBUS_MAX_BYTES 35          // write frame, header plus payload
`define JOYBUS_MAX_REPLY_BYTES 33    // read reply, payload plus crc
`define JOYBUS_HEADER_BYTES 3        // command plus two address bytes
`define JOYBUS_PAYLOAD_BYTES 32

// data crc, msb first, zero start value, no final inversion
`define JOYBUS_CRC_POLY 8'h85

`endif

// File: hw/joybus_pkg.sv
package joybus_pkg;

    // host command codes
    typedef enum logic [7:0] {
        CMD_INFO   = 8'h00,
        CMD_STATUS = 8'h01,
        CMD_READ   = 8'h02,
        CMD_WRITE  = 8'h03,
        CMD_RESET  = 8'hFF
    } joybus_cmd_e;

    // reply source selection
    typedef enum logic [1:0] {
        RESP_FIXED = 2'd0,
        RESP_ZEROS = 2'd1,
        RESP_NONE  = 2'd2
    } resp_kind_e;

    // one decoded host byte
    typedef struct packed {
        logic [7:0] data;
        logic [5:0] index;    // position in frame
    } rx_byte_t;

    // summary of a closed frame
    typedef struct packed {
        logic [7:0] cmd;
        logic [6:0] byte_count;
    } rx_frame_t;

    // what the encoder has to send
    typedef struct packed {
        resp_kind_e  kind;
        logic [31:0] fixed_data;    // left aligned
        logic [5:0]  data_bytes;
        logic        append_crc;
        logic        handoff_only;  // nothing on the line
    } resp_desc_t;

endpackage

// File: hw/joybus_rx_decoder.sv
`timescale 1ns/1ps
`include "joybus_defs.svh"

module joybus_rx_decoder
    import joybus_pkg::*;
(
    input  logic      sample_clk,
    input  logic      crc_reset,
    input  logic      data_rx,
    output logic      byte_valid,
    output rx_byte_t  byte_out,
    output logic      frame_valid,
    output rx_frame_t frame_out
);
    localparam int SAMPLE_AT = `JOYBUS_LEVEL_WIDTH + 1;
    localparam int CNT_W     = $clog2(`JOYBUS_BIT_WIDTH);
    localparam int IDLE_W    = $clog2(`JOYBUS_IDLE_CYCLES + 1);
    localparam int CNT_SAT   = `JOYBUS_MAX_BYTES + 1;

    logic              rx_meta;
    logic              rx_sync;
    logic              rx_prev;
    logic              fall;
    logic              sampling;
    logic [CNT_W-1:0]  sample_cnt;
    logic              sample_now;
    logic [7:0]        shift_reg;
    logic [7:0]        byte_next;
    logic [2:0]        bit_cnt;
    logic [6:0]        byte_cnt;
    logic [7:0]        cmd_q;
    logic [IDLE_W-1:0] idle_cnt;
    logic              in_frame;
    logic              frame_end;

    assign fall       = rx_prev & ~rx_sync;
    assign sample_now = sampling && (sample_cnt == CNT_W'(SAMPLE_AT));
    assign byte_next  = {shift_reg[6:0], rx_sync};
    assign frame_end  = in_frame && rx_sync &&
                        (idle_cnt == IDLE_W'(`JOYBUS_IDLE_CYCLES - 1));

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            rx_meta <= 1'b1;    // line idles high
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= data_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // each bit opens with a falling edge and is sampled in its second level
    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            sampling   <= 1'b0;
            sample_cnt <= '0;
        end else if (fall) begin
            sampling   <= 1'b1;
            sample_cnt <= CNT_W'(1);
        end else if (sample_now) begin
            sampling <= 1'b0;
        end else if (sampling) begin
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            idle_cnt <= '0;
        end else if (!rx_sync) begin
            idle_cnt <= '0;
        end else if (idle_cnt != IDLE_W'(`JOYBUS_IDLE_CYCLES)) begin
            idle_cnt <= idle_cnt + 1'b1;    // saturates
        end
    end

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            bit_cnt     <= '0;
            byte_cnt    <= '0;
            in_frame    <= 1'b0;
            byte_valid  <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            byte_valid  <= 1'b0;
            frame_valid <= 1'b0;
            if (sample_now) begin
                in_frame <= 1'b1;
                bit_cnt  <= bit_cnt + 1'b1;
                if (bit_cnt == 3'd7) begin
                    byte_valid <= 1'b1;
                    if (byte_cnt != 7'(CNT_SAT)) begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
            end else if (frame_end) begin
                frame_valid <= 1'b1;
                in_frame    <= 1'b0;
                bit_cnt     <= '0;    // drops the host stop bit
                byte_cnt    <= '0;
            end
        end
    end

    always_ff @(posedge sample_clk) begin
        if (sample_now) begin
            shift_reg <= byte_next;
            if (bit_cnt == 3'd7) begin
                byte_out.data  <= byte_next;
                byte_out.index <= byte_cnt[5:0];
                if (byte_cnt == '0) begin
                    cmd_q <= byte_next;    // first byte is the command
                end
            end
        end
        if (frame_end) begin
            frame_out.cmd        <= cmd_q;
            frame_out.byte_count <= byte_cnt;
        end
    end

    // a bit sample never lands on the cycle that closes the frame
    assert property (@(posedge sample_clk) disable iff (crc_reset)
        !(sample_now && frame_end));

endmodule

// File: hw/joybus_response_builder.sv
`timescale 1ns/1ps
`include "joybus_defs.svh"

module joybus_response_builder
    import joybus_pkg::*;
(
    input  logic        sample_clk,
    input  logic        crc_reset,
    input  logic        frame_valid,
    input  rx_frame_t   frame_in,
    input  logic [31:0] buttons,
    output logic        desc_valid,
    output resp_desc_t  desc
);

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            desc_valid <= 1'b0;
        end else begin
            desc_valid <= frame_valid;
        end
    end

    // decode the command, anything unexpected only hands off
    always_ff @(posedge sample_clk) begin
        if (frame_valid) begin
            desc.kind         <= RESP_NONE;
            desc.fixed_data   <= '0;
            desc.data_bytes   <= '0;
            desc.append_crc   <= 1'b0;
            desc.handoff_only <= 1'b1;
            case (frame_in.cmd)
                CMD_INFO, CMD_RESET: begin
                    if (frame_in.byte_count == 7'd1) begin
                        desc.kind         <= RESP_FIXED;
                        desc.fixed_data   <= 32'h0500_0000;    // standard pad, no pak
                        desc.data_bytes   <= 6'd3;
                        desc.handoff_only <= 1'b0;
                    end
                end
                CMD_STATUS: begin
                    if (frame_in.byte_count == 7'd1) begin
                        desc.kind         <= RESP_FIXED;
                        desc.fixed_data   <= buttons;    // sampled at frame end
                        desc.data_bytes   <= 6'd4;
                        desc.handoff_only <= 1'b0;
                    end
                end
                CMD_READ: begin
                    if (frame_in.byte_count == 7'(`JOYBUS_HEADER_BYTES)) begin
                        desc.kind         <= RESP_ZEROS;
                        desc.data_bytes   <= 6'(`JOYBUS_PAYLOAD_BYTES);
                        desc.append_crc   <= 1'b1;
                        desc.handoff_only <= 1'b0;
                    end
                end
                CMD_WRITE: begin
                    if (frame_in.byte_count == 7'(`JOYBUS_MAX_BYTES)) begin
                        desc.kind         <= RESP_ZEROS;
                        desc.append_crc   <= 1'b1;    // crc byte only
                        desc.handoff_only <= 1'b0;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: hw/joybus_crc8.sv
`timescale 1ns/1ps
`include "joybus_defs.svh"

module joybus_crc8
    import joybus_pkg::*;
(
    input  logic       sample_clk,
    input  logic       crc_reset,
    input  logic       byte_valid,
    input  rx_byte_t   byte_in,
    input  logic       frame_valid,
    input  rx_frame_t  frame_in,
    output logic       crc_valid,
    output logic [7:0] crc_value
);
    localparam logic [7:0] POLY = `JOYBUS_CRC_POLY;
    localparam int FIRST_IDX    = `JOYBUS_HEADER_BYTES;
    localparam int LAST_IDX     = `JOYBUS_MAX_BYTES - 1;
    localparam int ZCNT_W       = $clog2(`JOYBUS_PAYLOAD_BYTES + 1);

    logic [7:0]        remainder;
    logic              folding;
    logic [ZCNT_W-1:0] zero_cnt;
    logic              in_payload;

    // folds one whole byte per cycle with msb first
    function automatic logic [7:0] crc_fold(input logic [7:0] rem, input logic [7:0] data);
        logic [7:0] r;
        r = rem ^ data;
        for (int i = 0; i < 8; i++) begin
            r = r[7] ? ({r[6:0], 1'b0} ^ POLY) : {r[6:0], 1'b0};
        end
        return r;
    endfunction

    assign in_payload = (byte_in.index >= 6'(FIRST_IDX)) && (byte_in.index <= 6'(LAST_IDX));
    assign crc_value  = remainder;

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            crc_valid <= 1'b0;
            folding   <= 1'b0;
            zero_cnt  <= '0;
        end else begin
            crc_valid <= 1'b0;
            if (folding) begin
                zero_cnt <= zero_cnt - 1'b1;
                if (zero_cnt == ZCNT_W'(1)) begin
                    folding   <= 1'b0;
                    crc_valid <= 1'b1;
                end
            end else if (frame_valid) begin
                if (frame_in.cmd == CMD_READ) begin
                    folding  <= 1'b1;    // read data is all zero
                    zero_cnt <= ZCNT_W'(`JOYBUS_PAYLOAD_BYTES);
                end else begin
                    crc_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge sample_clk) begin
        if (byte_valid) begin
            if (byte_in.index == '0) begin
                remainder <= '0;    // new frame
            end else if (in_payload) begin
                remainder <= crc_fold(remainder, byte_in.data);
            end
        end else if (folding) begin
            remainder <= crc_fold(remainder, 8'h00);
        end
    end

    // result comes one cycle after the frame end, or after the zero folds of a read
    assert property (@(posedge sample_clk) disable iff (crc_reset)
        crc_valid |-> $past(frame_valid) || $past(frame_valid, `JOYBUS_PAYLOAD_BYTES + 1));

endmodule

// File: hw/joybus_tx_encoder.sv
`timescale 1ns/1ps
`include "joybus_defs.svh"

module joybus_tx_encoder
    import joybus_pkg::*;
(
    input  logic       sample_clk,
    input  logic       crc_reset,
    input  logic       desc_valid,
    input  resp_desc_t desc,
    input  logic       crc_valid,
    input  logic [7:0] crc_value,
    output logic       data_tx,
    output logic       busy,
    output logic       handoff
);
    localparam int LW = `JOYBUS_LEVEL_WIDTH;
    localparam int BW = `JOYBUS_BIT_WIDTH;
    localparam logic [BW-1:0] PAT_ZERO = {{3*LW{1'b0}}, {LW{1'b1}}};      // L,L,L,H
    localparam logic [BW-1:0] PAT_ONE  = {{LW{1'b0}}, {3*LW{1'b1}}};      // L,H,H,H
    localparam logic [BW-1:0] PAT_STOP = {{2*LW{1'b0}}, {2*LW{1'b1}}};    // L,L,H,H

    typedef enum logic [1:0] {ST_IDLE, ST_WAIT_CRC, ST_SEND, ST_STOP} tx_state_e;

    tx_state_e             state;
    resp_desc_t            desc_q;
    resp_desc_t            start_desc;
    logic                  start;
    logic [7:0]            crc_q;
    logic [31:0]           fixed_sh;
    logic [7:0]            tx_byte;
    logic [7:0]            next_byte;
    logic [2:0]            bit_idx;
    logic [$clog2(BW)-1:0] level_cnt;
    logic                  bit_end;
    logic [6:0]            byte_pos;
    logic [6:0]            total_bytes;
    logic [6:0]            start_total;
    logic [BW-1:0]         pattern;

    // reply starts once descriptor and crc are both in hand
    assign start_desc  = (state == ST_IDLE) ? desc : desc_q;
    assign start       = crc_valid && ((state == ST_WAIT_CRC) ||
                         (state == ST_IDLE && desc_valid && !desc.handoff_only));
    assign start_total = 7'(start_desc.data_bytes) + 7'(start_desc.append_crc);
    assign total_bytes = 7'(desc_q.data_bytes) + 7'(desc_q.append_crc);
    assign bit_end     = (level_cnt == ($clog2(BW))'(BW - 1));
    assign next_byte   = (byte_pos + 7'd1 < 7'(desc_q.data_bytes)) ?
                         ((desc_q.kind == RESP_FIXED) ? fixed_sh[23:16] : 8'h00) : crc_q;
    assign pattern     = (state == ST_STOP) ? PAT_STOP : (tx_byte[7] ? PAT_ONE : PAT_ZERO);
    assign data_tx     = (state == ST_SEND || state == ST_STOP) ?
                         pattern[BW-1-level_cnt] : 1'b1;    // released when idle
    assign busy        = (state != ST_IDLE);

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            state     <= ST_IDLE;
            handoff   <= 1'b0;
            level_cnt <= '0;
            bit_idx   <= '0;
            byte_pos  <= '0;
        end else begin
            handoff <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (desc_valid && desc.handoff_only) begin
                        handoff <= 1'b1;    // no reply for this frame
                    end else if (start) begin
                        state <= ST_SEND;
                    end else if (desc_valid) begin
                        state <= ST_WAIT_CRC;    // read crc still folding
                    end
                end
                ST_WAIT_CRC: begin
                    if (start) begin
                        state <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    level_cnt <= bit_end ? '0 : level_cnt + 1'b1;
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            byte_pos <= byte_pos + 1'b1;
                            if (byte_pos + 7'd1 == total_bytes) begin
                                state <= ST_STOP;
                            end
                        end
                    end
                end
                ST_STOP: begin
                    level_cnt <= bit_end ? '0 : level_cnt + 1'b1;
                    if (bit_end) begin
                        state   <= ST_IDLE;
                        handoff <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
            if (start) begin
                level_cnt <= '0;
                bit_idx   <= '0;
                byte_pos  <= '0;
            end
        end
    end

    // fixed word or zeros come first and the crc byte last
    always_ff @(posedge sample_clk) begin
        if (state == ST_IDLE && desc_valid) begin
            desc_q <= desc;
        end
        if (start) begin
            crc_q    <= crc_value;
            fixed_sh <= start_desc.fixed_data;
            if (start_desc.data_bytes != '0) begin
                tx_byte <= (start_desc.kind == RESP_FIXED) ? start_desc.fixed_data[31:24] : 8'h00;
            end else begin
                tx_byte <= crc_value;
            end
        end else if (state == ST_SEND && bit_end) begin
            if (bit_idx == 3'd7) begin
                tx_byte  <= next_byte;
                fixed_sh <= {fixed_sh[23:0], 8'h00};
            end else begin
                tx_byte <= {tx_byte[6:0], 1'b0};    // msb first
            end
        end
    end

    // a reply closes on a released line together with the handoff pulse
    assert property (@(posedge sample_clk) disable iff (crc_reset)
        $fell(busy) |-> handoff && $past(data_tx));

    // builder descriptor must fit one reply
    assert property (@(posedge sample_clk) disable iff (crc_reset)
        start |-> (start_total != '0) && (start_total <= 7'(`JOYBUS_MAX_REPLY_BYTES)));

endmodule

// File: hw/joybus_controller_top.sv
`timescale 1ns/1ps

module joybus_controller_top
    import joybus_pkg::*;
(
    input  logic        sample_clk,
    input  logic        crc_reset,
    input  logic        data_rx,
    input  logic [31:0] buttons,
    output logic        data_tx,
    output logic        busy,
    output logic        handoff
);
    logic       byte_valid;
    rx_byte_t   rx_byte;
    logic       frame_valid;
    rx_frame_t  rx_frame;
    logic       desc_valid;
    resp_desc_t resp_desc;
    logic       crc_valid;
    logic [7:0] crc_value;

    joybus_rx_decoder u_rx_decoder (
        .sample_clk  (sample_clk),
        .crc_reset   (crc_reset),
        .data_rx     (data_rx),
        .byte_valid  (byte_valid),
        .byte_out    (rx_byte),
        .frame_valid (frame_valid),
        .frame_out   (rx_frame)
    );

    joybus_response_builder u_response_builder (
        .sample_clk  (sample_clk),
        .crc_reset   (crc_reset),
        .frame_valid (frame_valid),
        .frame_in    (rx_frame),
        .buttons     (buttons),
        .desc_valid  (desc_valid),
        .desc        (resp_desc)
    );

    joybus_crc8 u_crc8 (
        .sample_clk  (sample_clk),
        .crc_reset   (crc_reset),
        .byte_valid  (byte_valid),
        .byte_in     (rx_byte),
        .frame_valid (frame_valid),
        .frame_in    (rx_frame),
        .crc_valid   (crc_valid),
        .crc_value   (crc_value)
    );

    // open-drain line, encoder holds it high when released
    joybus_tx_encoder u_tx_encoder (
        .sample_clk  (sample_clk),
        .crc_reset   (crc_reset),
        .desc_valid  (desc_valid),
        .desc        (resp_desc),
        .crc_valid   (crc_valid),
        .crc_value   (crc_value),
        .data_tx     (data_tx),
        .busy        (busy),
        .handoff     (handoff)
    );

endmodule

// File: bench/tb_joybus_controller.sv
`timescale 1ns/1ps
`include "joybus_defs.svh"

module tb_joybus_controller;
    localparam int REPLY_TIMEOUT = 200;    // cycles from host stop bit to first reply low
    localparam int SILENCE_CYCLES = 120;

    logic        sample_clk;
    logic        crc_reset;
    logic        data_rx;
    logic [31:0] buttons;
    logic        data_tx;
    logic        busy;
    logic        handoff;

    integer      seed;
    int          handoff_count = 0;
    int          handoff_start;
    logic [7:0]  payload [0:31];
    logic [7:0]  expect_q [$];
    logic [7:0]  reply_q [$];

    joybus_controller_top u_dut (
        .sample_clk (sample_clk),
        .crc_reset  (crc_reset),
        .data_rx    (data_rx),
        .buttons    (buttons),
        .data_tx    (data_tx),
        .busy       (busy),
        .handoff    (handoff)
    );

    initial begin
        sample_clk = 1'b0;
        forever #50 sample_clk = ~sample_clk;
    end

    always @(negedge sample_clk) begin
        if (handoff === 1'b1) begin
            handoff_count <= handoff_count + 1;
        end
    end

    task automatic fail_now();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    // bitwise data crc with msb first
    function automatic logic [7:0] crc8_step(input logic [7:0] crc, input logic [7:0] data);
        logic [7:0] c;
        logic       fb;
        c = crc;
        for (int i = 7; i >= 0; i--) begin
            fb = c[7] ^ data[i];
            c = {c[6:0], 1'b0};
            if (fb) begin
                c = c ^ `JOYBUS_CRC_POLY;
            end
        end
        return c;
    endfunction

    function automatic void joybus_expect(input logic [7:0] cmd, input logic [31:0] btn);
        logic [7:0] crc;
        expect_q.delete();
        crc = 8'h00;
        case (cmd)
            8'h00, 8'hFF: begin
                expect_q.push_back(8'h05);
                expect_q.push_back(8'h00);
                expect_q.push_back(8'h00);
            end
            8'h01: begin
                for (int i = 3; i >= 0; i--) begin
                    expect_q.push_back(btn[8*i +: 8]);
                end
            end
            8'h02: begin
                for (int i = 0; i < 32; i++) begin
                    expect_q.push_back(8'h00);    // reads return zeros without a pak
                    crc = crc8_step(crc, 8'h00);
                end
                expect_q.push_back(crc);
            end
            8'h03: begin
                for (int i = 0; i < 32; i++) begin
                    crc = crc8_step(crc, payload[i]);
                end
                expect_q.push_back(crc);
            end
            default: begin
            end
        endcase
    endfunction

    // host bit as the levels L b b H
    task automatic send_bit(input logic b);
        data_rx = 1'b0;
        repeat (`JOYBUS_LEVEL_WIDTH) @(negedge sample_clk);
        data_rx = b;
        repeat (2 * `JOYBUS_LEVEL_WIDTH) @(negedge sample_clk);
        data_rx = 1'b1;
        repeat (`JOYBUS_LEVEL_WIDTH) @(negedge sample_clk);
    endtask

    task automatic send_frame(input logic [7:0] cmd, input int nbytes);
        logic [7:0] b;
        for (int i = 0; i < nbytes; i++) begin
            if (i == 0) begin
                b = cmd;
            end else if (i < 3) begin
                b = (i == 1) ? 8'h80 : 8'h20;    // address bytes
            end else begin
                b = payload[(i - 3) % 32];
            end
            for (int j = 7; j >= 0; j--) begin
                send_bit(b[j]);
            end
        end
        send_bit(1'b1);    // host stop bit
    endtask

    task automatic wait_line(input logic level, input int limit, output bit seen);
        int n;
        n = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(negedge sample_clk);
            seen = (data_tx === level);
            n++;
        end
    endtask

    task automatic receive_reply();
        bit         seen;
        bit         bits [$];
        bit         stop_level;
        logic [7:0] b;
        reply_q.delete();
        wait_line(1'b0, REPLY_TIMEOUT, seen);
        assert (seen) else begin
            $display("no reply arrived on data_tx within %0d cycles", REPLY_TIMEOUT);
            fail_now();
        end
        buttons = $random(seed);    // the reply keeps the word captured at frame end
        while (seen) begin
            repeat (`JOYBUS_LEVEL_WIDTH + 1) @(negedge sample_clk);    // inside second level
            bits.push_back(data_tx);
            wait_line(1'b1, `JOYBUS_BIT_WIDTH, seen);
            assert (seen) else begin
                $display("data_tx stayed low for longer than one bit");
                fail_now();
            end
            wait_line(1'b0, 2 * `JOYBUS_BIT_WIDTH, seen);    // no edge means stop bit was last
        end
        stop_level = bits.pop_back();
        assert (stop_level == 1'b0) else begin
            $display("[FAIL] data_tx stop bit: got 0x%0h expected 0x0", stop_level);
            fail_now();
        end
        assert (bits.size() % 8 == 0) else begin
            $display("reply on data_tx ended in the middle of a byte");
            fail_now();
        end
        for (int i = 0; i < bits.size(); i += 8) begin
            for (int j = 0; j < 8; j++) begin
                b = {b[6:0], bits[i + j]};
            end
            reply_q.push_back(b);
        end
    endtask

    task automatic compare_reply();
        assert (reply_q.size() == expect_q.size()) else begin
            $display("[FAIL] data_tx reply length: got 0x%0h expected 0x%0h",
                     reply_q.size(), expect_q.size());
            fail_now();
        end
        for (int i = 0; i < expect_q.size(); i++) begin
            assert (reply_q[i] === expect_q[i]) else begin
                $display("[FAIL] data_tx byte %0d: got 0x%02h expected 0x%02h",
                         i, reply_q[i], expect_q[i]);
                fail_now();
            end
        end
    endtask

    task automatic check_handoff_idle();
        assert (handoff_count - handoff_start == 1) else begin
            $display("[FAIL] handoff pulses: got 0x%0h expected 0x1",
                     handoff_count - handoff_start);
            fail_now();
        end
        assert (busy === 1'b0) else begin
            $display("[FAIL] busy: got 0x%0h expected 0x0", busy);
            fail_now();
        end
    endtask

    task automatic run_reply(input logic [7:0] cmd, input int nbytes);
        handoff_start = handoff_count;
        joybus_expect(cmd, buttons);
        send_frame(cmd, nbytes);
        receive_reply();
        compare_reply();
        check_handoff_idle();
    endtask

    task automatic run_silent(input logic [7:0] cmd, input int nbytes);
        handoff_start = handoff_count;
        send_frame(cmd, nbytes);
        for (int i = 0; i < SILENCE_CYCLES; i++) begin
            @(negedge sample_clk);
            assert (data_tx === 1'b1) else begin
                $display("[FAIL] data_tx: got 0x%0h expected 0x1", data_tx);
                fail_now();
            end
        end
        check_handoff_idle();
    endtask

    initial begin
        crc_reset = 1'b1;
        data_rx = 1'b1;    // line idles high
        buttons = 32'h0;
        seed = 32'h076e12d9;
        repeat (2) @(negedge sample_clk);
        crc_reset = 1'b0;
        @(negedge sample_clk);
        assert (data_tx === 1'b1 && busy === 1'b0 && handoff === 1'b0) else begin
            $display("[FAIL] data_tx/busy/handoff after reset: got 0x%0h/0x%0h/0x%0h %s",
                     data_tx, busy, handoff, "expected 0x1/0x0/0x0");
            fail_now();
        end
        buttons = $random(seed);
        for (int i = 0; i < 32; i++) begin
            payload[i] = $random(seed);
        end
        run_reply(8'h00, 1);
        run_reply(8'hFF, 1);
        run_reply(8'h01, 1);
        run_reply(8'h03, 35);
        run_reply(8'h02, 3);
        run_silent(8'h40, 1);    // unknown command
        run_silent(8'h03, 13);    // short write
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: src.f
+incdir+include
hw/joybus_pkg.sv
hw/joybus_rx_decoder.sv
hw/joybus_response_builder.sv
hw/joybus_crc8.sv
hw/joybus_tx_encoder.sv
hw/joybus_controller_top.sv
bench/tb_joybus_controller.sv
